/* Makefile */
VERILATOR  ?= verilator
TOP        := txMuxTb
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/txMuxPkg.sv */
/*
 * TX request multiplexer shared definitions.
 * Widths, request/header/beat structs and the sequencer FSM encodings.
 */
`default_nettype none

package txMuxPkg;

    localparam int ADDR_W      = 62;  // DW address
    localparam int LEN_W       = 10;  // Length in DW
    localparam int DATA_W      = 64;
    localparam int DW_PER_BEAT = 2;
    localparam int MAX_CHNL    = 16;  // Bounds the channel index width

    typedef logic [$clog2(MAX_CHNL)-1:0] chnlT;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } reqT;

    // Outgoing request header
    typedef struct packed {
        logic              isWr;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        chnlT              tag;
        logic [3:0]        lastBe;
    } hdrT;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              start;
        logic              last;
        logic              endOffset;  // Last valid DW in the beat
    } beatT;

    // Beat flags, generated alongside the FIFO read enable
    typedef struct packed {
        logic valid;
        logic start;
        logic last;
        logic endOffset;
    } markT;

    typedef enum logic [3:0] {
        RD_WR = 4'b0001,  // Check reads first
        WR_RD = 4'b0010,  // Check writes first
        CAP   = 4'b0100,
        REL   = 4'b1000
    } capStateT;

    typedef enum logic [3:0] {
        IDLE = 4'b0001,
        RD   = 4'b0010,
        WR   = 4'b0100,
        WAIT = 4'b1000
    } mainStateT;

    // Index of the set bit in a one-hot channel vector
    function automatic chnlT oneHotToChnl(input logic [MAX_CHNL-1:0] vec);
        chnlT idx;
        idx = '0;
        for (int i = 0; i < MAX_CHNL; i++) begin
            if (vec[i]) begin
                idx = chnlT'(i);
            end
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

/* rtl/beatAligner.sv */
/*
 * Beat aligner.
 * Delays the beat flags and channel by the FIFO read latency, then
 * registers the selected channel's data with them.
 */
`default_nettype none

module beatAligner import txMuxPkg::*; #(
    parameter int NUM_CHNL     = 4,
    parameter int FIFO_LATENCY = 1
) (
    input  wire logic                           CLK,
    input  wire logic                           arstN,
    input  wire markT                           markIn,
    input  wire chnlT                           chnlIn,
    input  wire logic [NUM_CHNL-1:0][DATA_W-1:0] wrData,
    output logic                                txBeatValid,
    output beatT                                txBeat
);

    markT markLine [FIFO_LATENCY];
    chnlT chnlLine [FIFO_LATENCY];
    markT markOut;
    chnlT chnlOut;

    // Last stage lines up with the FIFO data
    assign markOut = markLine[FIFO_LATENCY-1];
    assign chnlOut = chnlLine[FIFO_LATENCY-1];

    // ----------------------------------------
    // Flag delay line
    // ----------------------------------------
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int k = 0; k < FIFO_LATENCY; k++) begin
                markLine[k] <= '0;
            end
            txBeatValid <= 1'b0;
        end else begin
            markLine[0] <= markIn;
            for (int k = 1; k < FIFO_LATENCY; k++) begin
                markLine[k] <= markLine[k-1];
            end
            txBeatValid <= markOut.valid;
        end
    end

    always_ff @(posedge CLK) begin
        chnlLine[0] <= chnlIn;
        for (int k = 1; k < FIFO_LATENCY; k++) begin
            chnlLine[k] <= chnlLine[k-1];
        end
        txBeat.data      <= wrData[chnlOut];  // Data mux
        txBeat.start     <= markOut.start;
        txBeat.last      <= markOut.last;
        txBeat.endOffset <= markOut.endOffset;
    end

endmodule

`default_nettype wire

/* rtl/beatCounter.sv */
/*
 * Write beat counter.
 * Drives the FIFO read enable of one channel for ceil(len/2) cycles
 * and marks the first and last beat.
 */
`default_nettype none

module beatCounter import txMuxPkg::*; #(
    parameter int NUM_CHNL = 4
) (
    input  wire logic             CLK,
    input  wire logic             arstN,
    input  wire logic             load,
    input  wire chnlT             chnl,
    input  wire logic [LEN_W-1:0] len,
    output logic [NUM_CHNL-1:0]   wrDataRen,
    output markT                  mark,
    output logic                  burstDone
);

    logic [LEN_W:0]   lenRound;   // One extra bit for rounding up
    logic [LEN_W-1:0] beatCount;
    logic [LEN_W-1:0] beatsLeft;
    logic             firstBeat;
    logic             lastOffset;

    assign lenRound  = {1'b0, len} + (LEN_W+1)'(DW_PER_BEAT - 1);
    assign beatCount = LEN_W'(lenRound / DW_PER_BEAT);

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            beatsLeft <= '0;
            wrDataRen <= '0;
            firstBeat <= 1'b0;
        end else if (load) begin
            beatsLeft <= beatCount;
            wrDataRen <= NUM_CHNL'(1) << chnl;
            firstBeat <= 1'b1;
        end else if (beatsLeft != '0) begin
            beatsLeft <= beatsLeft - 1'b1;
            firstBeat <= 1'b0;
            if (beatsLeft == LEN_W'(1)) begin
                wrDataRen <= '0;
            end
        end
    end

    // Odd len ends on DW 0, even len on DW 1
    always_ff @(posedge CLK) begin
        if (load) begin
            lastOffset <= ~len[0];
        end
    end

    assign mark.valid     = (beatsLeft != '0);
    assign mark.start     = firstBeat;
    assign mark.last      = (beatsLeft == LEN_W'(1));
    assign mark.endOffset = lastOffset;
    assign burstDone      = mark.last;

endmodule

`default_nettype wire

/* rtl/rrArbiter.sv */
/*
 * Round-robin channel arbiter.
 * Registers the winning channel and its request; the pointer moves past
 * a channel once it has been acknowledged.
 */
`default_nettype none

module rrArbiter import txMuxPkg::*; #(
    parameter int NUM_CHNL = 4
) (
    input  wire logic                CLK,
    input  wire logic                arstN,
    input  wire logic [NUM_CHNL-1:0] req,
    input  wire reqT  [NUM_CHNL-1:0] info,
    input  wire logic [NUM_CHNL-1:0] grantDone,  // One-hot ack pulse
    output logic                     pending,
    output chnlT                     chnl,
    output reqT                      sel
);

    chnlT lastPtr;  // Last acknowledged channel
    chnlT pick;
    logic found;

    // Search starts just after the last served channel
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = lastPtr;
        for (int i = 1; i <= NUM_CHNL; i++) begin
            idx = (int'(lastPtr) + i) % NUM_CHNL;
            if (!found && req[idx]) begin
                found = 1'b1;
                pick  = chnlT'(idx);
            end
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            lastPtr <= chnlT'(NUM_CHNL - 1);  // Channel 0 goes first
            pending <= 1'b0;
            chnl    <= '0;
        end else begin
            if (|grantDone) begin
                lastPtr <= oneHotToChnl(MAX_CHNL'(grantDone));
            end
            pending <= found;
            chnl    <= pick;
        end
    end

    always_ff @(posedge CLK) begin
        sel <= info[pick];
    end

endmodule

`default_nettype wire

/* rtl/txMux.sv */
/*
 * TX request multiplexer top level.
 * Round-robin read and write arbiters feed the sequencer, which issues
 * headers and streams write payload from the channel FIFOs.
 */
`default_nettype none

module txMux import txMuxPkg::*; #(
    parameter int NUM_CHNL     = 4,
    parameter int FIFO_LATENCY = 1
) (
    input  wire logic                            CLK,
    input  wire logic                            arstN,
    input  wire logic [NUM_CHNL-1:0]             rdReq,
    input  wire reqT  [NUM_CHNL-1:0]             rdReqInfo,
    output logic      [NUM_CHNL-1:0]             rdAck,
    input  wire logic [NUM_CHNL-1:0]             wrReq,
    input  wire reqT  [NUM_CHNL-1:0]             wrReqInfo,
    output logic      [NUM_CHNL-1:0]             wrAck,
    output logic      [NUM_CHNL-1:0]             wrDataRen,
    input  wire logic [NUM_CHNL-1:0][DATA_W-1:0] wrData,
    output logic                                 txHdrValid,
    output hdrT                                  txHdr,
    input  wire logic                            txHdrReady,
    output logic                                 txBeatValid,
    output beatT                                 txBeat
);

    logic             rdPending;
    logic             wrPending;
    chnlT             rdChnl;
    chnlT             wrChnl;
    reqT              rdSel;
    reqT              wrSel;
    logic             loadBeats;
    chnlT             loadChnl;
    logic [LEN_W-1:0] loadLen;
    logic             burstDone;
    markT             mark;
    chnlT             renChnl;

    // Channel being read this cycle
    assign renChnl = oneHotToChnl(MAX_CHNL'(wrDataRen));

    rrArbiter #(.NUM_CHNL(NUM_CHNL)) rdArb (
        .CLK      (CLK),
        .arstN    (arstN),
        .req      (rdReq),
        .info     (rdReqInfo),
        .grantDone(rdAck),
        .pending  (rdPending),
        .chnl     (rdChnl),
        .sel      (rdSel)
    );

    rrArbiter #(.NUM_CHNL(NUM_CHNL)) wrArb (
        .CLK      (CLK),
        .arstN    (arstN),
        .req      (wrReq),
        .info     (wrReqInfo),
        .grantDone(wrAck),
        .pending  (wrPending),
        .chnl     (wrChnl),
        .sel      (wrSel)
    );

    txSequencer #(.NUM_CHNL(NUM_CHNL)) txSequencer (
        .CLK       (CLK),
        .arstN     (arstN),
        .rdPending (rdPending),
        .wrPending (wrPending),
        .rdChnl    (rdChnl),
        .wrChnl    (wrChnl),
        .rdSel     (rdSel),
        .wrSel     (wrSel),
        .rdAck     (rdAck),
        .wrAck     (wrAck),
        .txHdrValid(txHdrValid),
        .txHdr     (txHdr),
        .txHdrReady(txHdrReady),
        .loadBeats (loadBeats),
        .loadChnl  (loadChnl),
        .loadLen   (loadLen),
        .burstDone (burstDone)
    );

    beatCounter #(.NUM_CHNL(NUM_CHNL)) beatCounter (
        .CLK      (CLK),
        .arstN    (arstN),
        .load     (loadBeats),
        .chnl     (loadChnl),
        .len      (loadLen),
        .wrDataRen(wrDataRen),
        .mark     (mark),
        .burstDone(burstDone)
    );

    beatAligner #(
        .NUM_CHNL    (NUM_CHNL),
        .FIFO_LATENCY(FIFO_LATENCY)
    ) beatAligner (
        .CLK        (CLK),
        .arstN      (arstN),
        .markIn     (mark),
        .chnlIn     (renChnl),
        .wrData     (wrData),
        .txBeatValid(txBeatValid),
        .txBeat     (txBeat)
    );

endmodule

`default_nettype wire

/* rtl/txSequencer.sv */
/*
 * Request sequencer.
 * Capture FSM alternates reads and writes, acks the winner and offers
 * the header; main FSM tracks the read or write burst behind it.
 */
`default_nettype none

module txSequencer import txMuxPkg::*; #(
    parameter int NUM_CHNL = 4
) (
    input  wire logic           CLK,
    input  wire logic           arstN,
    input  wire logic           rdPending,
    input  wire logic           wrPending,
    input  wire chnlT           rdChnl,
    input  wire chnlT           wrChnl,
    input  wire reqT            rdSel,
    input  wire reqT            wrSel,
    output logic [NUM_CHNL-1:0] rdAck,
    output logic [NUM_CHNL-1:0] wrAck,
    output logic                txHdrValid,
    output hdrT                 txHdr,
    input  wire logic           txHdrReady,
    output logic                loadBeats,
    output chnlT                loadChnl,
    output logic [LEN_W-1:0]    loadLen,
    input  wire logic           burstDone
);

    capStateT  capState;
    mainStateT mainState;

    // Request taken from the arbiter
    logic capIsWr;
    chnlT capChnl;
    reqT  capReq;

    logic hdrXfer;

    assign hdrXfer   = txHdrValid & txHdrReady;
    assign loadBeats = hdrXfer & txHdr.isWr;  // Reads produce no beats
    assign loadChnl  = capChnl;
    assign loadLen   = txHdr.len;

    // ----------------------------------------
    // Capture FSM
    // ----------------------------------------
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            capState   <= RD_WR;
            rdAck      <= '0;
            wrAck      <= '0;
            txHdrValid <= 1'b0;
        end else begin
            rdAck <= '0;  // Acks are single-cycle pulses
            wrAck <= '0;
            case (capState)
                RD_WR: begin
                    if (rdPending) begin
                        rdAck    <= NUM_CHNL'(1) << rdChnl;
                        capState <= CAP;
                    end else begin
                        capState <= WR_RD;
                    end
                end
                WR_RD: begin
                    if (wrPending) begin
                        wrAck    <= NUM_CHNL'(1) << wrChnl;
                        capState <= CAP;
                    end else begin
                        capState <= RD_WR;
                    end
                end
                CAP: capState <= REL;  // Header registered this cycle
                REL: begin
                    if (hdrXfer) begin
                        txHdrValid <= 1'b0;
                        // Other direction gets first look next
                        capState   <= capIsWr ? RD_WR : WR_RD;
                    end else if (mainState == IDLE) begin
                        txHdrValid <= 1'b1;
                    end
                end
                default: capState <= RD_WR;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        case (capState)
            RD_WR: begin
                if (rdPending) begin
                    capIsWr <= 1'b0;
                    capChnl <= rdChnl;
                    capReq  <= rdSel;
                end
            end
            WR_RD: begin
                if (wrPending) begin
                    capIsWr <= 1'b1;
                    capChnl <= wrChnl;
                    capReq  <= wrSel;
                end
            end
            CAP: begin
                txHdr.isWr   <= capIsWr;
                txHdr.addr   <= capReq.addr;
                txHdr.len    <= capReq.len;
                txHdr.tag    <= capIsWr ? chnlT'(0) : capChnl;  // Read tag is its channel
                txHdr.lastBe <= (capReq.len == LEN_W'(1)) ? 4'h0 : 4'hF;
            end
            default: ;
        endcase
    end

    // ----------------------------------------
    // Main FSM
    // ----------------------------------------
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            mainState <= IDLE;
        end else begin
            case (mainState)
                IDLE: begin
                    if (hdrXfer) begin
                        mainState <= txHdr.isWr ? WR : RD;
                    end
                end
                RD:   mainState <= IDLE;
                WR: begin
                    if (burstDone) begin
                        mainState <= WAIT;
                    end
                end
                WAIT: mainState <= IDLE;  // Gap after a write burst
                default: mainState <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src.f */
common/txMuxPkg.sv
rtl/rrArbiter.sv
rtl/txSequencer.sv
rtl/beatCounter.sv
rtl/beatAligner.sv
rtl/txMux.sv
verification/txMux_props.sv
verification/txMuxTb.sv

/* verification/txMuxTb.sv */
/*
 * Testbench for the TX request multiplexer.
 * Channel request and FIFO models, directed tests and a watchdog.
 */
`default_nettype none

module txMuxTb;
    import txMuxPkg::*;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CHNL     = 4;
    localparam int FIFO_LATENCY = 1;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 400;  // Generous bound per test
    localparam int HOLD_CYCLES  = 10;   // Stall length in the back-pressure test

    logic                            CLK = 1'b0;
    logic                            arstN;
    logic [NUM_CHNL-1:0]             rdReq = '0;
    reqT  [NUM_CHNL-1:0]             rdReqInfo = '0;
    logic [NUM_CHNL-1:0]             rdAck;
    logic [NUM_CHNL-1:0]             wrReq = '0;
    reqT  [NUM_CHNL-1:0]             wrReqInfo = '0;
    logic [NUM_CHNL-1:0]             wrAck;
    logic [NUM_CHNL-1:0]             wrDataRen;
    logic [NUM_CHNL-1:0][DATA_W-1:0] wrData;
    logic                            txHdrValid;
    hdrT                             txHdr;
    logic                            txHdrReady;
    logic                            txBeatValid;
    beatT                            txBeat;

    // Channel model state
    reqT  rdAskInfo [NUM_CHNL];
    reqT  wrAskInfo [NUM_CHNL];
    int   rdAsked [NUM_CHNL] = '{default: 0};
    int   wrAsked [NUM_CHNL] = '{default: 0};
    int   rdTaken [NUM_CHNL] = '{default: 0};
    int   wrTaken [NUM_CHNL] = '{default: 0};
    int   readIdx [NUM_CHNL] = '{default: 0};
    int   expIdx  [NUM_CHNL] = '{default: 0};
    int   rdAcks  [NUM_CHNL] = '{default: 0};
    logic [DATA_W-1:0] fifoPipe [NUM_CHNL][FIFO_LATENCY] = '{default: '0};

    hdrT  hdrQ [$];   // Transferred headers
    beatT beatQ [$];  // Output beats
    int   seed = 32'he766;
    int   testErrs = 0;
    int   totalErrs = 0;
    int   checks = 0;
    int   numTests = 0;

    txMux #(
        .NUM_CHNL    (NUM_CHNL),
        .FIFO_LATENCY(FIFO_LATENCY)
    ) u_dut (.*);

    bind txMux txMux_props #(
        .NUM_CHNL    (NUM_CHNL),
        .FIFO_LATENCY(FIFO_LATENCY)
    ) props (
        .CLK        (CLK),
        .arstN      (arstN),
        .rdAck      (rdAck),
        .wrAck      (wrAck),
        .wrDataRen  (wrDataRen),
        .txHdrValid (txHdrValid),
        .txHdrReady (txHdrReady),
        .txHdr      (txHdr),
        .txBeatValid(txBeatValid)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // Channel number in the top byte, beat index below
    function automatic logic [DATA_W-1:0] beatWord(input int ch, input int idx);
        return {8'(ch), 56'(idx)};
    endfunction

    function automatic logic [3:0] lastBeFor(input int len);
        return (len == 1) ? 4'h0 : 4'hF;
    endfunction

    // ----------------------------------------
    // Channel models
    // ----------------------------------------
    always @(posedge CLK) begin
        for (int i = 0; i < NUM_CHNL; i++) begin
            if (rdAck[i]) begin
                rdReq[i] <= 1'b0;
            end else if (!rdReq[i] && rdTaken[i] != rdAsked[i]) begin
                rdReq[i]     <= 1'b1;
                rdReqInfo[i] <= rdAskInfo[i];
                rdTaken[i]   = rdTaken[i] + 1;
            end
            if (wrAck[i]) begin
                wrReq[i] <= 1'b0;
            end else if (!wrReq[i] && wrTaken[i] != wrAsked[i]) begin
                wrReq[i]     <= 1'b1;
                wrReqInfo[i] <= wrAskInfo[i];
                wrTaken[i]   = wrTaken[i] + 1;
            end
        end
    end

    // FIFO read pipeline, FIFO_LATENCY stages deep
    always @(posedge CLK) begin
        for (int i = 0; i < NUM_CHNL; i++) begin
            if (wrDataRen[i]) begin
                fifoPipe[i][0] <= beatWord(i, readIdx[i]);
                readIdx[i]     <= readIdx[i] + 1;
            end
            for (int k = 1; k < FIFO_LATENCY; k++) begin
                fifoPipe[i][k] <= fifoPipe[i][k-1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CHNL; i++) begin
            wrData[i] = fifoPipe[i][FIFO_LATENCY-1];
        end
    end

    // Output monitor
    always @(posedge CLK) begin
        if (txHdrValid && txHdrReady) begin
            hdrQ.push_back(txHdr);
        end
        if (txBeatValid) begin
            beatQ.push_back(txBeat);
        end
        for (int i = 0; i < NUM_CHNL; i++) begin
            if (rdAck[i]) begin
                rdAcks[i]++;
            end
        end
    end

    // ----------------------------------------
    // Check and wait helpers
    // ----------------------------------------
    task automatic checkVal(input string name, input logic [127:0] act,
                            input logic [127:0] exp);
        checks++;
        assert (act === exp) else begin
            $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, act, exp);
            testErrs++;
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0t ns: %s", $time, what);
            testErrs++;
        end
    endtask

    task automatic endTest(input string name);
        $display("%-16s finished with %0d errors", name, testErrs);
        totalErrs += testErrs;
        testErrs = 0;
        numTests++;
    endtask

    task automatic settle(input int n);
        repeat (n) @(negedge CLK);
    endtask

    // Queue a request; the channel model raises it on the next edge
    task automatic ask(input logic isWr, input int ch, input logic [ADDR_W-1:0] addr,
                       input int len);
        if (isWr) begin
            wrAskInfo[ch] = '{addr: addr, len: LEN_W'(len)};
            wrAsked[ch]++;
        end else begin
            rdAskInfo[ch] = '{addr: addr, len: LEN_W'(len)};
            rdAsked[ch]++;
        end
    endtask

    task automatic waitQueues(input int hdrN, input int beatN, input int limit);
        int cyc;
        cyc = 0;
        while ((hdrQ.size() < hdrN || beatQ.size() < beatN) && cyc < limit) begin
            @(negedge CLK);
            cyc++;
        end
        checkTrue(hdrQ.size() >= hdrN, "timed out waiting for request headers");
        checkTrue(beatQ.size() >= beatN, "timed out waiting for write beats");
    endtask

    task automatic checkHdr(input hdrT h, input logic isWr, input int ch,
                            input logic [ADDR_W-1:0] addr, input int len);
        checkVal("txHdr.isWr", h.isWr, isWr);
        checkVal("txHdr.addr", h.addr, addr);
        checkVal("txHdr.len", h.len, len);
        checkVal("txHdr.lastBe", h.lastBe, lastBeFor(len));
        if (!isWr) begin
            checkVal("txHdr.tag", h.tag, ch);  // Read tag is the channel
        end
    endtask

    task automatic checkBurst(input int bb, input int ch, input int len);
        int   nb;
        beatT b;
        nb = (len + DW_PER_BEAT - 1) / DW_PER_BEAT;
        checkVal("txBeatValid count", beatQ.size() - bb, nb);
        for (int k = 0; k < nb && bb + k < beatQ.size(); k++) begin
            b = beatQ[bb + k];
            checkVal("txBeat.data", b.data, beatWord(ch, expIdx[ch] + k));
            checkVal("txBeat.start", b.start, k == 0);
            checkVal("txBeat.last", b.last, k == nb - 1);
            checkVal("txBeat.endOffset", b.endOffset, (len % 2 == 0));
        end
        expIdx[ch] += nb;
    endtask

    task automatic checkOutputsLow();
        checkVal("rdAck", rdAck, 0);
        checkVal("wrAck", wrAck, 0);
        checkVal("wrDataRen", wrDataRen, 0);
        checkVal("txHdrValid", txHdrValid, 0);
        checkVal("txBeatValid", txBeatValid, 0);
    endtask

    task automatic applyReset();
        @(posedge CLK);
        arstN <= 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            checkOutputsLow();
        end
        @(posedge CLK);
        arstN <= 1'b1;
    endtask

    task automatic writeBurst(input int ch, input logic [ADDR_W-1:0] addr, input int len);
        int hb;
        int bb;
        hb = hdrQ.size();
        bb = beatQ.size();
        settle(1);
        ask(1'b1, ch, addr, len);
        waitQueues(hb + 1, bb + (len + 1) / 2, 60);
        settle(FIFO_LATENCY + 3);  // Room for any extra beat
        if (hdrQ.size() > hb) begin
            checkHdr(hdrQ[hb], 1'b1, ch, addr, len);
        end
        checkBurst(bb, ch, len);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic testReset();
        applyReset();
        repeat (3) begin
            @(negedge CLK);
            checkOutputsLow();
        end
        endTest("reset");
    endtask

    task automatic testSingleRead();
        int hb;
        int bb;
        int a0;
        hb = hdrQ.size();
        bb = beatQ.size();
        a0 = rdAcks[2];
        settle(1);
        ask(1'b0, 2, 62'h0_1234_5678, 1);
        waitQueues(hb + 1, 0, 60);
        if (hdrQ.size() > hb) begin
            checkHdr(hdrQ[hb], 1'b0, 2, 62'h0_1234_5678, 1);
        end
        settle(FIFO_LATENCY + 4);
        checkVal("txBeatValid count", beatQ.size() - bb, 0);  // Reads carry no payload
        checkVal("rdAck[2] pulses", rdAcks[2] - a0, 1);
        endTest("single read");
    endtask

    task automatic testWrites();
        int rndLen;
        rndLen = ($random(seed) & 15) + 1;
        writeBurst(1, 62'h1000, 1);
        writeBurst(3, 62'h2000, 4);
        writeBurst(0, 62'h2800, 7);
        writeBurst(2, 62'h3000, rndLen);
        endTest("writes");
    endtask

    task automatic testRoundRobin();
        int hb;
        int a0;
        int cyc;
        int order [5] = '{0, 1, 2, 3, 0};
        applyReset();  // Pointer restarts so channel 0 goes first
        hb = hdrQ.size();
        a0 = rdAcks[0];
        cyc = 0;
        settle(1);
        for (int ch = 0; ch < NUM_CHNL; ch++) begin
            ask(1'b0, ch, 62'h100 + ch, 2);
        end
        while (rdAcks[0] == a0 && cyc < 40) begin
            @(negedge CLK);
            cyc++;
        end
        checkTrue(rdAcks[0] != a0, "channel 0 was never acknowledged");
        ask(1'b0, 0, 62'h200, 2);  // Re-request right after the ack
        waitQueues(hb + 5, 0, 150);
        for (int k = 0; k < 5 && hb + k < hdrQ.size(); k++) begin
            checkVal("txHdr.tag", hdrQ[hb + k].tag, order[k]);
        end
        endTest("round robin");
    endtask

    task automatic testAlternation();
        int   hb;
        int   bb;
        int   ch;
        beatT b;
        hb = hdrQ.size();
        bb = beatQ.size();
        settle(1);
        ask(1'b0, 0, 62'h500, 1);
        ask(1'b0, 1, 62'h600, 1);
        ask(1'b1, 2, 62'h700, 2);
        ask(1'b1, 3, 62'h800, 2);
        waitQueues(hb + 4, bb + 2, 150);
        settle(FIFO_LATENCY + 3);
        for (int k = 1; k < 4 && hb + k < hdrQ.size(); k++) begin
            checkVal("txHdr.isWr", hdrQ[hb + k].isWr, !hdrQ[hb + k - 1].isWr);
        end
        checkVal("txBeatValid count", beatQ.size() - bb, 2);
        for (int k = bb; k < beatQ.size(); k++) begin
            b  = beatQ[k];
            ch = int'(b.data[DATA_W-1 -: 8]);
            checkTrue(ch == 2 || ch == 3, "beat carries data of a channel that did not write");
            if (ch == 2 || ch == 3) begin
                checkVal("txBeat.data", b.data, beatWord(ch, expIdx[ch]));
                expIdx[ch]++;
            end
            checkVal("txBeat.start", b.start, 1);
            checkVal("txBeat.last", b.last, 1);
        end
        endTest("alternation");
    endtask

    task automatic testBackPressure();
        int  hb;
        int  bb;
        int  cyc;
        hdrT snap;
        hb  = hdrQ.size();
        bb  = beatQ.size();
        cyc = 0;
        @(posedge CLK);
        txHdrReady <= 1'b0;
        settle(1);
        ask(1'b1, 1, 62'h9000, 3);
        while (!txHdrValid && cyc < 40) begin
            @(negedge CLK);
            cyc++;
        end
        checkTrue(txHdrValid, "write header was never offered");
        snap = txHdr;
        ask(1'b0, 3, 62'hA000, 1);  // Must not be acked during the stall
        repeat (HOLD_CYCLES) begin
            @(negedge CLK);
            checkVal("txHdrValid", txHdrValid, 1);
            checkVal("txHdr", txHdr, snap);
            checkVal("rdAck", rdAck, 0);
            checkVal("wrAck", wrAck, 0);
            checkVal("wrDataRen", wrDataRen, 0);
        end
        @(posedge CLK);
        txHdrReady <= 1'b1;
        waitQueues(hb + 2, bb + 2, 100);
        settle(FIFO_LATENCY + 3);
        if (hdrQ.size() > hb + 1) begin
            checkVal("txHdr", hdrQ[hb], snap);
            checkHdr(hdrQ[hb], 1'b1, 1, 62'h9000, 3);
            checkHdr(hdrQ[hb + 1], 1'b0, 3, 62'hA000, 1);
        end
        checkBurst(bb, 1, 3);
        endTest("back-pressure");
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial begin
        arstN      = 1'b0;
        txHdrReady = 1'b1;
        testReset();
        testSingleRead();
        testWrites();
        testRoundRobin();
        testAlternation();
        testBackPressure();
        totalErrs += u_dut.props.failCount;  // Concurrent assertion failures
        $display("Summary: %0d tests, %0d checks, %0d errors", numTests, checks, totalErrs);
        if (totalErrs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 NUM_TESTS * TEST_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/txMux_props.sv */
/*
 * Handshake properties for the TX request multiplexer.
 * Bound into txMux by the testbench.
 */
`default_nettype none

module txMux_props import txMuxPkg::*; #(
    parameter int NUM_CHNL     = 4,
    parameter int FIFO_LATENCY = 1
) (
    input wire logic                CLK,
    input wire logic                arstN,
    input wire logic [NUM_CHNL-1:0] rdAck,
    input wire logic [NUM_CHNL-1:0] wrAck,
    input wire logic [NUM_CHNL-1:0] wrDataRen,
    input wire logic                txHdrValid,
    input wire logic                txHdrReady,
    input wire hdrT                 txHdr,
    input wire logic                txBeatValid
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;  // Read by the testbench at the end

    hdrStable: assert property (@(posedge CLK) disable iff (!arstN)
        (txHdrValid && !txHdrReady) |=> (txHdrValid && $stable(txHdr)))
        else begin
            $error("txHdr changed or was dropped before its transfer");
            failCount++;
        end

    rdAckPulse: assert property (@(posedge CLK) disable iff (!arstN)
        (rdAck != '0) |=> (rdAck == '0))
        else begin
            $error("rdAck held for more than one cycle");
            failCount++;
        end

    wrAckPulse: assert property (@(posedge CLK) disable iff (!arstN)
        (wrAck != '0) |=> (wrAck == '0))
        else begin
            $error("wrAck held for more than one cycle");
            failCount++;
        end

    renOneHot: assert property (@(posedge CLK) disable iff (!arstN)
        $onehot0(wrDataRen))
        else begin
            $error("wrDataRen has more than one bit set");
            failCount++;
        end

    // A beat needs a read enable FIFO_LATENCY+1 cycles earlier
    beatFromRen: assert property (@(posedge CLK) disable iff (!arstN)
        !$past(|wrDataRen, FIFO_LATENCY + 1) |-> !txBeatValid)
        else begin
            $error("txBeatValid without a matching read enable");
            failCount++;
        end

endmodule

`default_nettype wire
